// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_osc_meas
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/edge_count.sv ====
`timescale 1ns/10ps

module edge_count
    import osc_meas_pkg::*;
(
    input  logic                cfg_clk,
    input  logic                i_rst_n,
    input  logic [SAMPLE_W-1:0] i_midline,
    input  logic                i_valid,
    input  logic [SAMPLE_W-1:0] i_sample,
    input  logic                i_last,
    input  logic                i_win_done,
    input  logic [SAMPLE_W-1:0] i_max,
    input  logic [SAMPLE_W-1:0] i_min,
    output logic                o_result_valid,
    output logic [SAMPLE_W-1:0] o_max,
    output logic [SAMPLE_W-1:0] o_min,
    output logic [EDGE_W-1:0]   o_edges
);

    logic [SAMPLE_W-1:0] prev_sample;                // carries across windows
    logic [EDGE_W-1:0]   cnt;
    logic                crossing;
    logic [EDGE_W-1:0]   cnt_inc;

    assign crossing = (i_sample >= i_midline) && (prev_sample < i_midline);
    assign cnt_inc  = cnt + EDGE_W'(crossing);

    always_ff @(posedge cfg_clk)
    begin
        if (!i_rst_n)
        begin
            prev_sample    <= '0;
            cnt            <= '0;
            o_result_valid <= 1'b0;
        end
        else
        begin
            o_result_valid <= i_valid && i_win_done;
            if (i_valid)
            begin
                prev_sample <= i_sample;
                if (i_last)
                    cnt <= '0;                       // restart for next window
                else
                    cnt <= cnt_inc;
            end
        end
    end

    // results leave together, one cycle after the last sample
    always_ff @(posedge cfg_clk)
    begin
        if (i_valid && i_win_done)
        begin
            o_max   <= i_max;
            o_min   <= i_min;
            o_edges <= cnt_inc;
        end
    end

    a_done_on_last: assert property (@(posedge cfg_clk) disable iff (!i_rst_n)
        i_win_done |-> (i_valid && i_last));

endmodule

// ==== hdl/gate_window.sv ====
`timescale 1ns/10ps

module gate_window
    import osc_meas_pkg::*;
(
    input  logic                cfg_clk,
    input  logic                i_rst_n,
    input  logic                i_enable,
    input  logic                i_sample_valid,
    input  logic [SAMPLE_W-1:0] i_sample,
    output logic                o_valid,
    output logic [SAMPLE_W-1:0] o_sample,
    output logic                o_first,
    output logic                o_last
);

    win_state_e            state;
    logic [GATE_IDX_W-1:0] idx;                      // position inside window
    logic                  accept;
    logic                  at_last;

    assign accept  = i_sample_valid && i_enable;
    assign at_last = (idx == GATE_IDX_W'(GATE_LEN - 1));

    always_ff @(posedge cfg_clk)
    begin
        if (!i_rst_n)
        begin
            state   <= WIN_IDLE;
            idx     <= '0;
            o_valid <= 1'b0;
            o_first <= 1'b0;
            o_last  <= 1'b0;
        end
        else
        begin
            o_valid <= accept;
            if (!i_enable)
            begin
                state <= WIN_IDLE;                   // partial window dropped
                idx   <= '0;
            end
            else if (accept)
            begin
                o_first <= (state == WIN_IDLE);
                o_last  <= at_last;
                if (at_last)
                begin
                    state <= WIN_IDLE;
                    idx   <= '0;
                end
                else
                begin
                    state <= WIN_RUN;
                    idx   <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge cfg_clk)
    begin
        if (accept)
            o_sample <= i_sample;
    end

    // idle always sits at the window start
    a_idle_idx: assert property (@(posedge cfg_clk) disable iff (!i_rst_n)
        (state == WIN_IDLE) |-> (idx == '0));

endmodule

// ==== hdl/meas_regs.sv ====
`timescale 1ns/10ps

module meas_regs
    import osc_meas_pkg::*;
(
    input  logic                  cfg_clk,
    input  logic                  i_rst_n,
    // apb slave
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [APB_DATA_W-1:0] i_pwdata,
    output logic [APB_DATA_W-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    // window results
    input  logic                  i_result_valid,
    input  logic [SAMPLE_W-1:0]   i_max,
    input  logic [SAMPLE_W-1:0]   i_min,
    input  logic [EDGE_W-1:0]     i_edges,
    // control back to the sample path
    output logic                  o_enable,
    output logic [SAMPLE_W-1:0]   o_midline
);

    logic                  access;
    logic                  addr_hit;
    logic                  ctrl_wr;
    logic [APB_DATA_W-1:0] rd_mux;
    logic [APB_DATA_W-1:0] ctrl_word;

    logic [SAMPLE_W-1:0]   reg_max;
    logic [SAMPLE_W-1:0]   reg_min;
    logic [SAMPLE_W-1:0]   reg_vpp;
    logic [EDGE_W-1:0]     reg_edges;
    logic [WIN_CNT_W-1:0]  win_cnt;

    assign access  = i_psel && i_penable;                       // access phase
    assign ctrl_wr = access && i_pwrite && (i_paddr == REG_CTRL);

    always_comb
    begin
        ctrl_word = '0;
        ctrl_word[CTRL_EN_BIT] = o_enable;
        ctrl_word[CTRL_MID_LSB +: SAMPLE_W] = o_midline;
    end

    // offset decode
    always_comb
    begin
        addr_hit = 1'b1;
        case (i_paddr)
            REG_CTRL:   rd_mux = ctrl_word;
            REG_STATUS: rd_mux = APB_DATA_W'(win_cnt);
            REG_MAX:    rd_mux = APB_DATA_W'(reg_max);
            REG_MIN:    rd_mux = APB_DATA_W'(reg_min);
            REG_VPP:    rd_mux = APB_DATA_W'(reg_vpp);
            REG_EDGES:  rd_mux = APB_DATA_W'(reg_edges);
            default:
            begin
                addr_hit = 1'b0;
                rd_mux   = '0;
            end
        endcase
    end

    assign o_prdata  = (access && !i_pwrite) ? rd_mux : '0;
    assign o_pready  = 1'b1;                                    // no wait states
    assign o_pslverr = access && !addr_hit;

    // ctrl, only writable register
    always_ff @(posedge cfg_clk)
    begin
        if (!i_rst_n)
        begin
            o_enable  <= 1'b0;
            o_midline <= MIDLINE_RST;
        end
        else if (ctrl_wr)
        begin
            o_enable  <= i_pwdata[CTRL_EN_BIT];
            o_midline <= i_pwdata[CTRL_MID_LSB +: SAMPLE_W];
        end
    end

    // capture finished window
    always_ff @(posedge cfg_clk)
    begin
        if (!i_rst_n)
        begin
            reg_max   <= '0;
            reg_min   <= '0;
            reg_vpp   <= '0;
            reg_edges <= '0;
            win_cnt   <= '0;
        end
        else if (i_result_valid)
        begin
            reg_max   <= i_max;
            reg_min   <= i_min;
            reg_vpp   <= i_max - i_min;                         // max >= min upstream
            reg_edges <= i_edges;
            win_cnt   <= win_cnt + 1'b1;
        end
    end

    a_penable_sel: assert property (@(posedge cfg_clk) disable iff (!i_rst_n)
        i_penable |-> i_psel);

endmodule

// ==== hdl/osc_meas_pkg.sv ====
package osc_meas_pkg;

    // sample path
    localparam int SAMPLE_W    = 8;
    localparam int GATE_LEN    = 64;                 // samples per gate window
    localparam int GATE_IDX_W  = 6;
    localparam int EDGE_W      = 7;                  // holds up to GATE_LEN
    localparam int WIN_CNT_W   = 16;

    // apb
    localparam int APB_ADDR_W  = 8;
    localparam int APB_DATA_W  = 32;

    // ctrl register fields
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_MID_LSB = 8;
    localparam logic [SAMPLE_W-1:0] MIDLINE_RST = 8'd128;

    // register offsets
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL   = 8'h00,                          // enable and midline
        REG_STATUS = 8'h04,                          // completed windows
        REG_MAX    = 8'h08,
        REG_MIN    = 8'h0C,
        REG_VPP    = 8'h10,
        REG_EDGES  = 8'h14
    } reg_addr_e;

    // gate window controller
    typedef enum logic {
        WIN_IDLE = 1'b0,                             // waiting for first sample
        WIN_RUN  = 1'b1
    } win_state_e;

endpackage

// ==== hdl/osc_meas_top.sv ====
`timescale 1ns/10ps

module osc_meas_top
    import osc_meas_pkg::*;
(
    input  logic                  cfg_clk,
    input  logic                  i_rst_n,
    input  logic                  i_sample_valid,
    input  logic [SAMPLE_W-1:0]   i_sample,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [APB_DATA_W-1:0] i_pwdata,
    output logic [APB_DATA_W-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr
);

    // control from registers
    logic                enable;
    logic [SAMPLE_W-1:0] midline;

    // stage 1 to stage 2
    logic                gw_valid;
    logic [SAMPLE_W-1:0] gw_sample;
    logic                gw_first;
    logic                gw_last;

    // stage 2 to stage 3
    logic                pk_valid;
    logic [SAMPLE_W-1:0] pk_sample;
    logic                pk_last;
    logic                pk_win_done;
    logic [SAMPLE_W-1:0] pk_max;
    logic [SAMPLE_W-1:0] pk_min;

    // stage 3 to registers
    logic                res_valid;
    logic [SAMPLE_W-1:0] res_max;
    logic [SAMPLE_W-1:0] res_min;
    logic [EDGE_W-1:0]   res_edges;

    gate_window i_gate_window (
        .cfg_clk        (cfg_clk),
        .i_rst_n        (i_rst_n),
        .i_enable       (enable),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .o_valid        (gw_valid),
        .o_sample       (gw_sample),
        .o_first        (gw_first),
        .o_last         (gw_last)
    );

    peak_track i_peak_track (
        .cfg_clk    (cfg_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (gw_valid),
        .i_sample   (gw_sample),
        .i_first    (gw_first),
        .i_last     (gw_last),
        .o_valid    (pk_valid),
        .o_sample   (pk_sample),
        .o_last     (pk_last),
        .o_win_done (pk_win_done),
        .o_max      (pk_max),
        .o_min      (pk_min)
    );

    edge_count i_edge_count (
        .cfg_clk        (cfg_clk),
        .i_rst_n        (i_rst_n),
        .i_midline      (midline),
        .i_valid        (pk_valid),
        .i_sample       (pk_sample),
        .i_last         (pk_last),
        .i_win_done     (pk_win_done),
        .i_max          (pk_max),
        .i_min          (pk_min),
        .o_result_valid (res_valid),
        .o_max          (res_max),
        .o_min          (res_min),
        .o_edges        (res_edges)
    );

    meas_regs i_meas_regs (
        .cfg_clk        (cfg_clk),
        .i_rst_n        (i_rst_n),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .i_result_valid (res_valid),
        .i_max          (res_max),
        .i_min          (res_min),
        .i_edges        (res_edges),
        .o_enable       (enable),
        .o_midline      (midline)
    );

endmodule

// ==== hdl/peak_track.sv ====
`timescale 1ns/10ps

module peak_track
    import osc_meas_pkg::*;
(
    input  logic                cfg_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  logic [SAMPLE_W-1:0] i_sample,
    input  logic                i_first,
    input  logic                i_last,
    output logic                o_valid,
    output logic [SAMPLE_W-1:0] o_sample,
    output logic                o_last,
    output logic                o_win_done,
    output logic [SAMPLE_W-1:0] o_max,
    output logic [SAMPLE_W-1:0] o_min
);

    logic [SAMPLE_W-1:0] run_max;
    logic [SAMPLE_W-1:0] run_min;
    logic [SAMPLE_W-1:0] nxt_max;
    logic [SAMPLE_W-1:0] nxt_min;

    // first sample of a window reloads both trackers
    always_comb
    begin
        nxt_max = run_max;
        nxt_min = run_min;
        if (i_first || (i_sample > run_max))
            nxt_max = i_sample;
        if (i_first || (i_sample < run_min))
            nxt_min = i_sample;
    end

    always_ff @(posedge cfg_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid    <= 1'b0;
            o_last     <= 1'b0;
            o_win_done <= 1'b0;
        end
        else
        begin
            o_valid    <= i_valid;
            o_win_done <= i_valid && i_last;
            if (i_valid)
                o_last <= i_last;
        end
    end

    always_ff @(posedge cfg_clk)
    begin
        if (i_valid)
        begin
            o_sample <= i_sample;
            run_max  <= nxt_max;
            run_min  <= nxt_min;
        end
    end

    assign o_max = run_max;                          // final pair lines up with last
    assign o_min = run_min;

    a_peak_order: assert property (@(posedge cfg_clk) disable iff (!i_rst_n)
        o_win_done |-> (o_max >= o_min));

endmodule

// ==== verif/osc_meas_testdata.txt ====
# W offset data | R offset expected_data expected_slverr | S sixteen samples | E test_number
# all values hex except the test number
# test 1: reset values, samples while disabled are dropped
R 00 00008000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
S FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00
R 04 00000000 0
R 08 00000000 0
E 1
# test 2: triangle window
W 00 00008001
S 20 26 2C 32 38 3E 44 4A 50 56 5C 62 68 6E 74 7A
S 80 86 8C 92 98 9E A4 AA B0 B6 BC C2 C8 CE D4 DA
S D4 CE C8 C2 BC B6 B0 AA A4 9E 98 92 8C 86 80 7A
S 74 6E 68 62 5C 56 50 4A 44 3E 38 32 2C 26 20 1A
R 08 000000DA 0
R 0C 0000001A 0
R 10 000000C0 0
R 14 00000001 0
R 04 00000001 0
E 2
# test 3: square wave, 12 sample period, then midline above the wave
S 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30
S 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30 30 30 D0 D0
S D0 D0 D0 D0 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0
S 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30
R 10 000000A0 0
R 14 00000005 0
R 04 00000002 0
W 00 0000E001
R 00 0000E001 0
S 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30
S 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30 30 30 D0 D0
S D0 D0 D0 D0 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0
S 30 30 30 30 30 30 D0 D0 D0 D0 D0 D0 30 30 30 30
R 14 00000000 0
R 04 00000003 0
E 3
# test 4: extremes sit on the window edges
S 38 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
S 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
S 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
S 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 70
R 08 00000070 0
R 0C 00000038 0
R 10 00000038 0
R 04 00000004 0
S A0 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90
S 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90
S 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90
S 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 88
R 08 000000A0 0
R 0C 00000088 0
R 10 00000018 0
R 04 00000005 0
E 4
# test 5: unmapped offsets and a read-only register
R 40 00000000 1
R 18 00000000 1
W 08 000000FF
R 08 000000A0 0
E 5
# test 6: enable cleared in mid-window
S F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0 F0
R 04 00000005 0
W 00 0000E000
W 00 0000E001
S 50 50 48 50 50 50 50 50 50 50 50 50 50 50 50 50
S 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
S 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
R 04 00000005 0
S 50 50 50 50 50 50 50 60 50 50 50 50 50 50 50 50
R 04 00000006 0
R 08 00000060 0
R 0C 00000048 0
R 10 00000018 0
E 6

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen
(
    output logic o_cfg_clk
);

    initial
    begin
        o_cfg_clk = 1'b0;
        forever
            #50 o_cfg_clk = ~o_cfg_clk;              // 100 ns period
    end

endmodule

// ==== verif/tb_osc_meas.sv ====
`timescale 1ns/10ps

module tb_osc_meas
    import osc_meas_pkg::*;
();

    localparam int    RST_CYCLES   = 5;
    localparam int    READ_DELAY   = 4;             // last sample to result registers
    localparam int    READY_LIMIT  = 16;            // cycles allowed for pready
    localparam int    SAMPLES_LINE = 16;
    localparam string DATA_FILE    = "verif/osc_meas_testdata.txt";

    logic                  cfg_clk;
    logic                  rst_n;
    logic                  sample_valid;
    logic [SAMPLE_W-1:0]   sample;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    int fd;
    int err_cnt;
    int check_cnt;
    int test_cnt;
    int test_fail_cnt;
    int test_err_base;
    bit broken;                                     // run cannot go on
    bit samples_pending;

    tb_clk_gen i_tb_clk_gen (
        .o_cfg_clk (cfg_clk)
    );

    osc_meas_top i_osc_meas_top (
        .cfg_clk        (cfg_clk),
        .i_rst_n        (rst_n),
        .i_sample_valid (sample_valid),
        .i_sample       (sample),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr)
    );

    function automatic string reg_name(input logic [APB_ADDR_W-1:0] addr);
        case (addr)
            REG_CTRL:   return "CTRL";
            REG_STATUS: return "STATUS";
            REG_MAX:    return "MAX";
            REG_MIN:    return "MIN";
            REG_VPP:    return "VPP";
            REG_EDGES:  return "EDGES";
            default:    return "unmapped";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        check_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("Mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act);
        end
    endtask

    // setup then access, called and left on a falling edge
    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
        int  waited;
        bit  done;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge cfg_clk);
        penable = 1'b1;
        waited  = 0;
        done    = 1'b0;
        rdata   = '0;
        err     = 1'b0;
        while (!done && waited < READY_LIMIT)
        begin
            @(posedge cfg_clk);                     // pre-edge values of the access cycle
            if (pready)
            begin
                done  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            waited++;
        end
        @(negedge cfg_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (!done)
        begin
            $display("no APB ready from the DUT within %0d cycles at offset 0x%02h",
                     READY_LIMIT, addr);
            broken = 1'b1;
        end
    endtask

    task automatic run_write();
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] data;
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        if ($fscanf(fd, "%h %h", addr, data) != 2)
        begin
            $display("malformed write line in the test data file");
            broken = 1'b1;
        end
        else
            apb_xfer(1'b1, addr, data, rdata, err);
    endtask

    task automatic run_read();
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] exp_data;
        logic [APB_DATA_W-1:0] exp_err;
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        if ($fscanf(fd, "%h %h %h", addr, exp_data, exp_err) != 3)
        begin
            $display("malformed read line in the test data file");
            broken = 1'b1;
        end
        else
        begin
            if (samples_pending)
            begin
                repeat (READ_DELAY) @(negedge cfg_clk);   // results settle
                samples_pending = 1'b0;
            end
            apb_xfer(1'b0, addr, '0, rdata, err);
            if (!broken)
            begin
                compare_value(reg_name(addr), exp_data, rdata);
                compare_value("pslverr", exp_err, {31'b0, err});
            end
        end
    endtask

    // consecutive sample lines form one unbroken stream
    task automatic send_samples();
        logic [SAMPLE_W-1:0] vals [SAMPLES_LINE];
        int                  n;
        n = 0;
        while (n < SAMPLES_LINE && $fscanf(fd, "%h", vals[n]) == 1)
            n++;
        if (n != SAMPLES_LINE)
        begin
            $display("sample line with fewer than %0d values in the test data file",
                     SAMPLES_LINE);
            broken = 1'b1;
        end
        else
        begin
            for (int i = 0; i < SAMPLES_LINE; i++)
            begin
                sample_valid = 1'b1;
                sample       = vals[i];
                @(negedge cfg_clk);
            end
            sample_valid    = 1'b0;
            samples_pending = 1'b1;
        end
    endtask

    task automatic close_test();
        int num;
        int errs;
        if ($fscanf(fd, "%d", num) != 1)
        begin
            $display("malformed test end line in the test data file");
            broken = 1'b1;
        end
        else
        begin
            errs = err_cnt - test_err_base;
            test_cnt++;
            if (errs == 0)
                $display("test %0d passed", num);
            else
            begin
                test_fail_cnt++;
                $display("test %0d failed with %0d mismatches", num, errs);
            end
            test_err_base = err_cnt;
        end
    endtask

    initial
    begin
        string           cmd;
        logic [8*160-1:0] skip_buf;
        int              code;
        bit              done;
        rst_n           = 1'b0;
        sample_valid    = 1'b0;
        sample          = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        err_cnt         = 0;
        check_cnt       = 0;
        test_cnt        = 0;
        test_fail_cnt   = 0;
        test_err_base   = 0;
        broken          = 1'b0;
        samples_pending = 1'b0;
        done            = 1'b0;
        repeat (RST_CYCLES) @(posedge cfg_clk);
        @(negedge cfg_clk);
        rst_n = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the test data file %s", DATA_FILE);
            broken = 1'b1;
        end
        while (!done && !broken)
        begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1)
                done = 1'b1;                        // end of file
            else if (cmd.getc(0) == "#")
                code = $fgets(skip_buf, fd);
            else if (cmd == "W")
                run_write();
            else if (cmd == "R")
                run_read();
            else if (cmd == "S")
                send_samples();
            else if (cmd == "E")
                close_test();
            else
            begin
                $display("unknown command %s in the test data file", cmd);
                broken = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0 && !broken && test_cnt > 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/osc_meas_pkg.sv
hdl/gate_window.sv
hdl/peak_track.sv
hdl/edge_count.sv
hdl/meas_regs.sv
hdl/osc_meas_top.sv
verif/tb_clk_gen.sv
verif/tb_osc_meas.sv
